// File: Bender.yml
package:
  name: lane

sources:
  - lane_pkg.sv
  - lane_if.sv
  - lane_sequencer.sv
  - operand_requester.sv
  - lane_vrf.sv
  - operand_queue.sv
  - lane_alu.sv
  - lane.sv
  - target: test
    files:
      - tb_lane.sv

// File: lane.sv
`timescale 1ns/1ps

module lane #(
  parameter int unsigned NrBanks    = 4,
  parameter int unsigned QueueDepth = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Instruction input
  input  logic                insn_valid_i,
  output logic                insn_ready_o,
  input  lane_pkg::op_e       insn_op_i,
  input  lane_pkg::vreg_t     insn_vd_i,
  input  lane_pkg::vreg_t     insn_vs1_i,
  input  lane_pkg::vreg_t     insn_vs2_i,
  input  lane_pkg::vl_t       insn_vl_i,
  output logic                insn_done_o,
  // Load unit
  input  logic                ldu_valid_i,
  input  lane_pkg::vreg_t     ldu_vreg_i,
  input  lane_pkg::elem_idx_t ldu_elem_i,
  input  lane_pkg::elem_t     ldu_wdata_i,
  output logic                ldu_gnt_o,
  // Store unit
  output lane_pkg::elem_t     stu_operand_o,
  output logic                stu_operand_valid_o,
  input  logic                stu_operand_ready_i
);

  opreq_if                    opreq ();
  vrf_if #(.NrBanks(NrBanks)) vrf ();
  opq_if                      opq_a ();
  opq_if                      opq_b ();
  opq_if                      opq_st ();

  lane_pkg::op_e    alu_op;
  lane_pkg::vreg_t  alu_vd;
  lane_pkg::elem_t  a_data, b_data, wb_wdata;
  logic             a_valid, b_valid, a_pop, b_pop;
  logic             wb_req, wb_gnt, wb_done;
  lane_pkg::vaddr_t wb_addr;
  logic             st_pop;

  assign st_pop = stu_operand_valid_o && stu_operand_ready_i;

  ////////////////////////////////////////
  // Control and operand fetch
  ////////////////////////////////////////

  lane_sequencer i_lane_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_valid_i (insn_valid_i),
    .insn_ready_o (insn_ready_o),
    .insn_op_i    (insn_op_i),
    .insn_vd_i    (insn_vd_i),
    .insn_vs1_i   (insn_vs1_i),
    .insn_vs2_i   (insn_vs2_i),
    .insn_vl_i    (insn_vl_i),
    .insn_done_o  (insn_done_o),
    .opreq        (opreq),
    .alu_op_o     (alu_op),
    .alu_vd_o     (alu_vd),
    .wb_done_i    (wb_done),
    .st_pop_i     (st_pop)
  );

  operand_requester #(
    .NrBanks    (NrBanks),
    .QueueDepth (QueueDepth)
  ) i_operand_requester (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .opreq       (opreq),
    .vrf         (vrf),
    .opq_a       (opq_a),
    .opq_b       (opq_b),
    .opq_st      (opq_st),
    .wb_req_i    (wb_req),
    .wb_addr_i   (wb_addr),
    .wb_wdata_i  (wb_wdata),
    .wb_gnt_o    (wb_gnt),
    .ldu_valid_i (ldu_valid_i),
    .ldu_vreg_i  (ldu_vreg_i),
    .ldu_elem_i  (ldu_elem_i),
    .ldu_wdata_i (ldu_wdata_i),
    .ldu_gnt_o   (ldu_gnt_o)
  );

  lane_vrf #(.NrBanks(NrBanks)) i_lane_vrf (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .vrf    (vrf)
  );

  ////////////////////////////////////////
  // Operand queues and ALU
  ////////////////////////////////////////

  operand_queue #(.QueueDepth(QueueDepth)) i_opq_a (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .opq     (opq_a),
    .data_o  (a_data),
    .valid_o (a_valid),
    .pop_i   (a_pop)
  );

  operand_queue #(.QueueDepth(QueueDepth)) i_opq_b (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .opq     (opq_b),
    .data_o  (b_data),
    .valid_o (b_valid),
    .pop_i   (b_pop)
  );

  // Store queue feeds the store port directly
  operand_queue #(.QueueDepth(QueueDepth)) i_opq_st (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .opq     (opq_st),
    .data_o  (stu_operand_o),
    .valid_o (stu_operand_valid_o),
    .pop_i   (stu_operand_ready_i)
  );

  lane_alu i_lane_alu (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .op_i       (alu_op),
    .vd_i       (alu_vd),
    .a_i        (a_data),
    .a_valid_i  (a_valid),
    .b_i        (b_data),
    .b_valid_i  (b_valid),
    .a_pop_o    (a_pop),
    .b_pop_o    (b_pop),
    .wb_req_o   (wb_req),
    .wb_addr_o  (wb_addr),
    .wb_wdata_o (wb_wdata),
    .wb_gnt_i   (wb_gnt),
    .wb_done_o  (wb_done)
  );

endmodule

// File: lane_alu.sv
`timescale 1ns/1ps

module lane_alu (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  lane_pkg::op_e    op_i,
  input  lane_pkg::vreg_t  vd_i,
  input  lane_pkg::elem_t  a_i,
  input  logic             a_valid_i,
  input  lane_pkg::elem_t  b_i,
  input  logic             b_valid_i,
  output logic             a_pop_o,
  output logic             b_pop_o,
  output logic             wb_req_o,
  output lane_pkg::vaddr_t wb_addr_o,
  output lane_pkg::elem_t  wb_wdata_o,
  input  logic             wb_gnt_i,
  output logic             wb_done_o
);

  lane_pkg::elem_idx_t elem_q;
  logic                accept;

  // Request as soon as both heads are there
  assign wb_req_o  = a_valid_i && b_valid_i && (op_i != lane_pkg::VSTORE);
  assign wb_addr_o = {vd_i, elem_q};
  assign accept    = wb_req_o && wb_gnt_i;
  assign a_pop_o   = accept;
  assign b_pop_o   = accept;
  assign wb_done_o = accept;

  // A holds vs1, B holds vs2
  always_comb begin
    unique case (op_i)
      lane_pkg::VADD: wb_wdata_o = a_i + b_i;
      lane_pkg::VSUB: wb_wdata_o = b_i - a_i;  // vs2 minus vs1
      lane_pkg::VAND: wb_wdata_o = a_i & b_i;
      lane_pkg::VOR:  wb_wdata_o = a_i | b_i;
      lane_pkg::VXOR: wb_wdata_o = a_i ^ b_i;
      default:        wb_wdata_o = '0;
    endcase
  end

  // Element index of the next writeback
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      elem_q <= '0;
    end else if (op_i == lane_pkg::VSTORE) begin
      elem_q <= '0;
    end else if (accept) begin
      elem_q <= elem_q + 1'b1;
    end
  end

endmodule

// File: lane_if.sv
`timescale 1ns/1ps

// Command from the sequencer to the operand requester
interface opreq_if;
  logic            valid;
  logic            ready;
  lane_pkg::op_e   op;
  lane_pkg::vreg_t vs1;
  lane_pkg::vreg_t vs2;
  lane_pkg::vl_t   vl;

  modport master (output valid, op, vs1, vs2, vl, input ready);
  modport slave  (input valid, op, vs1, vs2, vl, output ready);
endinterface

// Per-bank access to the register file
interface vrf_if #(
  parameter int unsigned NrBanks = 4
);
  logic             [NrBanks-1:0] req;
  logic             [NrBanks-1:0] wen;
  lane_pkg::vaddr_t [NrBanks-1:0] addr;
  lane_pkg::elem_t  [NrBanks-1:0] wdata;
  lane_pkg::opq_e   [NrBanks-1:0] tgt;
  // Read response, one cycle after req
  logic             [NrBanks-1:0] rvalid;
  lane_pkg::elem_t  [NrBanks-1:0] rdata;
  lane_pkg::opq_e   [NrBanks-1:0] rtgt;

  modport master (output req, wen, addr, wdata, tgt, input rvalid, rdata, rtgt);
  modport slave  (input req, wen, addr, wdata, tgt, output rvalid, rdata, rtgt);
endinterface

// Read data into one operand queue, credits flow back
interface opq_if;
  logic            push;
  lane_pkg::elem_t data;
  logic            credit;

  modport requester (output push, data, input credit);
  modport queue     (input push, data, output credit);
endinterface

// File: lane_pkg.sv
package lane_pkg;

  // Datapath and register file geometry
  localparam int unsigned ElemWidth = 64;
  localparam int unsigned NrVRegs   = 32;
  localparam int unsigned MaxVl     = 16;
  localparam int unsigned VrfWords  = NrVRegs * MaxVl;

  typedef logic [ElemWidth-1:0]        elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]  vreg_t;
  typedef logic [$clog2(MaxVl+1)-1:0]  vl_t;
  typedef logic [$clog2(MaxVl)-1:0]    elem_idx_t;
  // Word address, register times MaxVl plus element
  typedef logic [$clog2(VrfWords)-1:0] vaddr_t;

  typedef enum logic [2:0] {
    VADD   = 3'd0,
    VSUB   = 3'd1,
    VAND   = 3'd2,
    VOR    = 3'd3,
    VXOR   = 3'd4,
    VSTORE = 3'd5
  } op_e;

  // Operand queue that receives a VRF read
  typedef enum logic [1:0] {
    OPQ_A  = 2'd0,
    OPQ_B  = 2'd1,
    OPQ_ST = 2'd2
  } opq_e;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DRAIN = 2'd2
  } seq_state_e;

endpackage

// File: lane_sequencer.sv
`timescale 1ns/1ps

module lane_sequencer (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            insn_valid_i,
  output logic            insn_ready_o,
  input  lane_pkg::op_e   insn_op_i,
  input  lane_pkg::vreg_t insn_vd_i,
  input  lane_pkg::vreg_t insn_vs1_i,
  input  lane_pkg::vreg_t insn_vs2_i,
  input  lane_pkg::vl_t   insn_vl_i,
  output logic            insn_done_o,
  opreq_if.master         opreq,
  output lane_pkg::op_e   alu_op_o,
  output lane_pkg::vreg_t alu_vd_o,
  input  logic            wb_done_i,
  input  logic            st_pop_i
);

  lane_pkg::seq_state_e state_q, state_d;
  lane_pkg::op_e        op_q;
  lane_pkg::vreg_t      vd_q, vs1_q, vs2_q;
  lane_pkg::vl_t        vl_q;
  lane_pkg::vl_t        cnt_q, cnt_d;
  logic                 done_q;
  logic                 completion;

  assign insn_ready_o = state_q == lane_pkg::IDLE;
  assign insn_done_o  = done_q;

  // Command stays up until the requester has issued every element
  assign opreq.valid = state_q == lane_pkg::RUN;
  assign opreq.op    = op_q;
  assign opreq.vs1   = vs1_q;
  assign opreq.vs2   = vs2_q;
  assign opreq.vl    = vl_q;

  // VSTORE toward the ALU while idle, so its element counter restarts
  assign alu_op_o = (state_q == lane_pkg::IDLE) ? lane_pkg::VSTORE : op_q;
  assign alu_vd_o = vd_q;

  // Finished elements come back from the ALU or the store port
  assign completion = (op_q == lane_pkg::VSTORE) ? st_pop_i : wb_done_i;
  assign cnt_d      = cnt_q + lane_pkg::vl_t'(completion);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      lane_pkg::IDLE:  if (insn_valid_i) state_d = lane_pkg::RUN;
      lane_pkg::RUN:   if (opreq.ready) state_d = lane_pkg::DRAIN;
      lane_pkg::DRAIN: if (cnt_d == vl_q) state_d = lane_pkg::IDLE;
      default:         state_d = lane_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= lane_pkg::IDLE;
      op_q    <= lane_pkg::VSTORE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= (state_q == lane_pkg::DRAIN) && (cnt_d == vl_q);
      if (state_q == lane_pkg::IDLE) begin
        cnt_q <= '0;
        if (insn_valid_i) op_q <= insn_op_i;
      end else begin
        cnt_q <= cnt_d;
      end
    end
  end

  // Operand fields of the accepted instruction
  always_ff @(posedge clk_i) begin
    if (insn_valid_i && insn_ready_o) begin
      vd_q  <= insn_vd_i;
      vs1_q <= insn_vs1_i;
      vs2_q <= insn_vs2_i;
      vl_q  <= insn_vl_i;
    end
  end

endmodule

// File: lane_vrf.sv
`timescale 1ns/1ps

module lane_vrf #(
  parameter int unsigned NrBanks = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  vrf_if.slave vrf
);

  localparam int unsigned BankWords = lane_pkg::VrfWords / NrBanks;
  localparam int unsigned BankSel   = $clog2(NrBanks);
  localparam int unsigned RowW      = $clog2(BankWords);

  lane_pkg::elem_t mem_q [NrBanks][BankWords];
  logic [RowW-1:0] row [NrBanks];

  // Address over bank count stays unique inside one bank under the skew
  always_comb begin
    for (int b = 0; b < NrBanks; b++) begin
      row[b] = RowW'(vrf.addr[b] >> BankSel);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < NrBanks; b++) begin
      if (vrf.req[b] && vrf.wen[b]) begin
        mem_q[b][row[b]] <= vrf.wdata[b];
      end
      // Read data carries its target queue along
      if (vrf.req[b] && !vrf.wen[b]) begin
        vrf.rdata[b] <= mem_q[b][row[b]];
        vrf.rtgt[b]  <= vrf.tgt[b];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vrf.rvalid <= '0;
    end else begin
      vrf.rvalid <= vrf.req & ~vrf.wen;
    end
  end

endmodule

// File: operand_queue.sv
`timescale 1ns/1ps

module operand_queue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  opq_if.queue            opq,
  output lane_pkg::elem_t data_o,
  output logic            valid_o,
  input  logic            pop_i
);

  localparam int unsigned PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntW = $clog2(QueueDepth + 1);

  lane_pkg::elem_t fifo_q [QueueDepth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            pop;

  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign valid_o = cnt_q != '0;
  assign data_o  = fifo_q[rd_ptr_q];
  assign pop     = pop_i && valid_o;

  // One credit per freed slot
  assign opq.credit = pop;

  // Credits keep pushes within the depth
  always_ff @(posedge clk_i) begin
    if (opq.push) fifo_q[wr_ptr_q] <= opq.data;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (opq.push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      cnt_q <= cnt_q + CntW'(opq.push) - CntW'(pop);
    end
  end

endmodule

// File: operand_requester.sv
`timescale 1ns/1ps

module operand_requester #(
  parameter int unsigned NrBanks    = 4,
  parameter int unsigned QueueDepth = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  opreq_if.slave              opreq,
  vrf_if.master               vrf,
  opq_if.requester            opq_a,
  opq_if.requester            opq_b,
  opq_if.requester            opq_st,
  input  logic                wb_req_i,
  input  lane_pkg::vaddr_t    wb_addr_i,
  input  lane_pkg::elem_t     wb_wdata_i,
  output logic                wb_gnt_o,
  input  logic                ldu_valid_i,
  input  lane_pkg::vreg_t     ldu_vreg_i,
  input  lane_pkg::elem_idx_t ldu_elem_i,
  input  lane_pkg::elem_t     ldu_wdata_i,
  output logic                ldu_gnt_o
);

  localparam int unsigned BankW = (NrBanks > 1) ? $clog2(NrBanks) : 1;
  localparam int unsigned CntW  = $clog2(QueueDepth + 1);

  typedef logic [BankW-1:0] bank_t;

  // Skewed mapping, register index shifts the starting bank
  function automatic bank_t bank_of(lane_pkg::vreg_t vreg, lane_pkg::elem_idx_t elem);
    return bank_t'((int'(vreg) + int'(elem)) % NrBanks);
  endfunction

  lane_pkg::elem_idx_t elem_q;
  logic                half_q;
  logic [CntW-1:0]     credit_q [3];
  logic                is_st, last_elem, conflict;
  logic                cred_a_ok, cred_b_ok, issue_a, issue_b;
  lane_pkg::vaddr_t    addr_a, addr_b, ld_addr;
  bank_t               bank_a, bank_b, bank_wb, bank_ld;
  logic [NrBanks-1:0]  busy;
  logic [2:0]          issued, returned, push;
  lane_pkg::elem_t     push_data [3];

  assign is_st     = opreq.op == lane_pkg::VSTORE;
  assign last_elem = (lane_pkg::vl_t'(elem_q) + lane_pkg::vl_t'(1)) == opreq.vl;
  assign addr_a    = {opreq.vs1, elem_q};
  assign addr_b    = {opreq.vs2, elem_q};
  assign ld_addr   = {ldu_vreg_i, ldu_elem_i};
  assign bank_a    = bank_of(opreq.vs1, elem_q);
  assign bank_b    = bank_of(opreq.vs2, elem_q);
  assign bank_ld   = bank_of(ldu_vreg_i, ldu_elem_i);
  assign bank_wb   = bank_of(lane_pkg::vreg_t'(wb_addr_i >> $bits(lane_pkg::elem_idx_t)),
                             lane_pkg::elem_idx_t'(wb_addr_i));

  ////////////////////////////////////////
  // Bank arbitration
  ////////////////////////////////////////

  // ALU writeback always wins, load next
  assign wb_gnt_o  = wb_req_i;
  assign ldu_gnt_o = ldu_valid_i && !(wb_req_i && bank_ld == bank_wb);

  always_comb begin
    for (int b = 0; b < NrBanks; b++) begin
      busy[b] = (wb_req_i && bank_wb == bank_t'(b)) || (ldu_gnt_o && bank_ld == bank_t'(b));
    end
  end

  assign conflict  = bank_a == bank_b;
  assign cred_a_ok = credit_q[lane_pkg::OPQ_A] != '0;
  assign cred_b_ok = is_st ? (credit_q[lane_pkg::OPQ_ST] != '0)
                           : (credit_q[lane_pkg::OPQ_B] != '0);

  // Same bank for A and B: A first, B on a later cycle
  always_comb begin
    issue_a = 1'b0;
    issue_b = 1'b0;
    if (opreq.valid) begin
      if (is_st || half_q) begin
        issue_b = !busy[bank_b] && cred_b_ok;
      end else if (conflict) begin
        issue_a = !busy[bank_a] && cred_a_ok;
      end else begin
        issue_a = !busy[bank_a] && !busy[bank_b] && cred_a_ok && cred_b_ok;
        issue_b = issue_a;
      end
    end
  end

  // The B side closes each element
  assign opreq.ready = issue_b && last_elem;

  always_comb begin
    for (int b = 0; b < NrBanks; b++) begin
      vrf.req[b]   = 1'b0;
      vrf.wen[b]   = 1'b0;
      vrf.addr[b]  = addr_a;
      vrf.wdata[b] = wb_wdata_i;
      vrf.tgt[b]   = lane_pkg::OPQ_A;
      if (wb_req_i && bank_wb == bank_t'(b)) begin
        vrf.req[b]  = 1'b1;
        vrf.wen[b]  = 1'b1;
        vrf.addr[b] = wb_addr_i;
      end else if (ldu_gnt_o && bank_ld == bank_t'(b)) begin
        vrf.req[b]   = 1'b1;
        vrf.wen[b]   = 1'b1;
        vrf.addr[b]  = ld_addr;
        vrf.wdata[b] = ldu_wdata_i;
      end else if (issue_a && bank_a == bank_t'(b)) begin
        vrf.req[b] = 1'b1;
      end else if (issue_b && bank_b == bank_t'(b)) begin
        vrf.req[b]  = 1'b1;
        vrf.addr[b] = addr_b;
        vrf.tgt[b]  = is_st ? lane_pkg::OPQ_ST : lane_pkg::OPQ_B;
      end
    end
  end

  ////////////////////////////////////////
  // Read data steering and credits
  ////////////////////////////////////////

  always_comb begin
    push = '0;
    for (int q = 0; q < 3; q++) begin
      push_data[q] = '0;
    end
    for (int b = 0; b < NrBanks; b++) begin
      if (vrf.rvalid[b]) begin
        push[vrf.rtgt[b]]      = 1'b1;
        push_data[vrf.rtgt[b]] = vrf.rdata[b];
      end
    end
  end

  assign opq_a.push  = push[lane_pkg::OPQ_A];
  assign opq_a.data  = push_data[lane_pkg::OPQ_A];
  assign opq_b.push  = push[lane_pkg::OPQ_B];
  assign opq_b.data  = push_data[lane_pkg::OPQ_B];
  assign opq_st.push = push[lane_pkg::OPQ_ST];
  assign opq_st.data = push_data[lane_pkg::OPQ_ST];

  assign issued[lane_pkg::OPQ_A]    = issue_a;
  assign issued[lane_pkg::OPQ_B]    = issue_b && !is_st;
  assign issued[lane_pkg::OPQ_ST]   = issue_b && is_st;
  assign returned[lane_pkg::OPQ_A]  = opq_a.credit;
  assign returned[lane_pkg::OPQ_B]  = opq_b.credit;
  assign returned[lane_pkg::OPQ_ST] = opq_st.credit;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      elem_q <= '0;
      half_q <= 1'b0;
      for (int q = 0; q < 3; q++) begin
        credit_q[q] <= CntW'(QueueDepth);
      end
    end else begin
      if (issue_b) elem_q <= last_elem ? '0 : elem_q + 1'b1;
      if (issue_a || issue_b) half_q <= issue_a && !issue_b;
      for (int q = 0; q < 3; q++) begin
        credit_q[q] <= credit_q[q] - CntW'(issued[q]) + CntW'(returned[q]);
      end
    end
  end

endmodule

// File: project.f
lane_pkg.sv
lane_if.sv
lane_sequencer.sv
operand_requester.sv
lane_vrf.sv
operand_queue.sv
lane_alu.sv
lane.sv
tb_lane.sv

// File: tb_lane.sv
`timescale 1ns/1ps

module tb_lane;

  localparam int unsigned NrBanks    = 4;
  localparam int unsigned QueueDepth = 4;
  localparam int          Timeout    = 2000;

  logic                clk_i;
  logic                rst_ni;
  logic                insn_valid_i;
  logic                insn_ready_o;
  lane_pkg::op_e       insn_op_i;
  lane_pkg::vreg_t     insn_vd_i;
  lane_pkg::vreg_t     insn_vs1_i;
  lane_pkg::vreg_t     insn_vs2_i;
  lane_pkg::vl_t       insn_vl_i;
  logic                insn_done_o;
  logic                ldu_valid_i;
  lane_pkg::vreg_t     ldu_vreg_i;
  lane_pkg::elem_idx_t ldu_elem_i;
  lane_pkg::elem_t     ldu_wdata_i;
  logic                ldu_gnt_o;
  lane_pkg::elem_t     stu_operand_o;
  logic                stu_operand_valid_o;
  logic                stu_operand_ready_i;

  // Register file model and expected store stream
  lane_pkg::elem_t model_vrf [lane_pkg::NrVRegs][lane_pkg::MaxVl];
  lane_pkg::elem_t exp_q [$];
  logic [31:0]     rng;
  logic [31:0]     bp_rng;
  logic            bp_en;
  int              accepted;
  int              done_cnt;

  lane #(
    .NrBanks    (NrBanks),
    .QueueDepth (QueueDepth)
  ) i_lane (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .insn_valid_i        (insn_valid_i),
    .insn_ready_o        (insn_ready_o),
    .insn_op_i           (insn_op_i),
    .insn_vd_i           (insn_vd_i),
    .insn_vs1_i          (insn_vs1_i),
    .insn_vs2_i          (insn_vs2_i),
    .insn_vl_i           (insn_vl_i),
    .insn_done_o         (insn_done_o),
    .ldu_valid_i         (ldu_valid_i),
    .ldu_vreg_i          (ldu_vreg_i),
    .ldu_elem_i          (ldu_elem_i),
    .ldu_wdata_i         (ldu_wdata_i),
    .ldu_gnt_o           (ldu_gnt_o),
    .stu_operand_o       (stu_operand_o),
    .stu_operand_valid_o (stu_operand_valid_o),
    .stu_operand_ready_i (stu_operand_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic lane_pkg::elem_t rand_elem();
    lane_pkg::elem_t e;
    e[63:32] = next_rand();
    e[31:0]  = next_rand();
    return e;
  endfunction

  // Expected result of one element, A from vs1 and B from vs2
  function automatic lane_pkg::elem_t ref_result(input lane_pkg::op_e op,
                                                 input lane_pkg::elem_t vs1,
                                                 input lane_pkg::elem_t vs2);
    case (op)
      lane_pkg::VADD: return vs1 + vs2;
      lane_pkg::VSUB: return vs2 - vs1;
      lane_pkg::VAND: return vs1 & vs2;
      lane_pkg::VOR:  return vs1 | vs2;
      lane_pkg::VXOR: return vs1 ^ vs2;
      default:        return vs2;
    endcase
  endfunction

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped after the first failure");
  endtask

  task automatic check_value(input logic [63:0] expected, input logic [63:0] actual,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR @ %0t: %s, expected %h, got %h", $time, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout after %0d cycles while waiting for %s", Timeout, what);
    abort_run();
  endtask

  task automatic load_elem(input lane_pkg::vreg_t vreg, input int elem,
                           input lane_pkg::elem_t data);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    ldu_valid_i <= 1'b1;
    ldu_vreg_i  <= vreg;
    ldu_elem_i  <= lane_pkg::elem_idx_t'(elem);
    ldu_wdata_i <= data;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > Timeout) timeout_fail("the load grant");
    end while (!ldu_gnt_o);
    ldu_valid_i <= 1'b0;
    model_vrf[vreg][elem] = data;
  endtask

  task automatic run_insn(input lane_pkg::op_e op, input lane_pkg::vreg_t vd,
                          input lane_pkg::vreg_t vs1, input lane_pkg::vreg_t vs2,
                          input int vl);
    int cycles;
    if (op == lane_pkg::VSTORE) begin
      for (int e = 0; e < vl; e++) exp_q.push_back(model_vrf[vs2][e]);
    end
    @(posedge clk_i);
    insn_valid_i <= 1'b1;
    insn_op_i    <= op;
    insn_vd_i    <= vd;
    insn_vs1_i   <= vs1;
    insn_vs2_i   <= vs2;
    insn_vl_i    <= lane_pkg::vl_t'(vl);
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > Timeout) timeout_fail("instruction acceptance");
    end while (!insn_ready_o);
    insn_valid_i <= 1'b0;
    accepted++;
    @(posedge clk_i);
    check_value(0, insn_ready_o, "insn_ready_o after acceptance");
    cycles = 0;
    while (!insn_done_o) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > Timeout) timeout_fail("the instruction done pulse");
    end
    if (op == lane_pkg::VSTORE) begin
      check_value(0, exp_q.size(), "store elements still missing at done");
    end else begin
      for (int e = 0; e < vl; e++) begin
        model_vrf[vd][e] = ref_result(op, model_vrf[vs1][e], model_vrf[vs2][e]);
      end
    end
  endtask

  task automatic store_reg(input lane_pkg::vreg_t vreg, input int vl);
    run_insn(lane_pkg::VSTORE, '0, '0, vreg, vl);
  endtask

  ////////////////////////////////////////
  // Store port and done monitors
  ////////////////////////////////////////

  // Random ready while back-pressure is on
  initial begin
    bp_rng = 32'hcfdf;
    stu_operand_ready_i <= 1'b1;
    forever begin
      @(posedge clk_i);
      bp_rng = xorshift32(bp_rng);
      stu_operand_ready_i <= bp_en ? bp_rng[7] : 1'b1;
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni && stu_operand_valid_o && stu_operand_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Store port delivered an element that was not expected");
        abort_run();
      end else begin
        check_value(exp_q.pop_front(), stu_operand_o, "store element");
      end
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni && insn_done_o) done_cnt++;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    lane_pkg::vreg_t vd, vs1, vs2;
    lane_pkg::op_e   op;
    logic [2:0]      sel;
    int              vl;
    rng          = 32'hcfdf;
    accepted     = 0;
    done_cnt     = 0;
    bp_en        <= 1'b0;
    rst_ni       <= 1'b0;
    insn_valid_i <= 1'b0;
    insn_op_i    <= lane_pkg::VADD;
    insn_vd_i    <= '0;
    insn_vs1_i   <= '0;
    insn_vs2_i   <= '0;
    insn_vl_i    <= '0;
    ldu_valid_i  <= 1'b0;
    ldu_vreg_i   <= '0;
    ldu_elem_i   <= '0;
    ldu_wdata_i  <= '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    @(posedge clk_i);
    check_value(1, insn_ready_o, "insn_ready_o after reset");
    check_value(0, insn_done_o, "insn_done_o after reset");
    check_value(0, stu_operand_valid_o, "stu_operand_valid_o after reset");
    check_value(0, ldu_gnt_o, "ldu_gnt_o after reset");

    // Fill the whole register file through the load port
    for (int r = 0; r < lane_pkg::NrVRegs; r++) begin
      for (int e = 0; e < lane_pkg::MaxVl; e++) load_elem(r, e, rand_elem());
    end
    for (int r = 0; r < 4; r++) store_reg(r, 16);

    // Each ALU operation at full length
    for (int i = 0; i < 5; i++) begin
      vd  = lane_pkg::vreg_t'(next_rand());
      vs1 = lane_pkg::vreg_t'(next_rand());
      vs2 = lane_pkg::vreg_t'(next_rand());
      run_insn(lane_pkg::op_e'(3'(i)), vd, vs1, vs2, 16);
      store_reg(vd, 16);
    end

    // Short vectors leave the tail of vd alone
    run_insn(lane_pkg::VADD, 5'd7, 5'd8, 5'd9, 1);
    store_reg(5'd7, 16);
    store_reg(5'd9, 1);
    run_insn(lane_pkg::VXOR, 5'd10, 5'd11, 5'd12, 16);
    store_reg(5'd10, 16);
    for (int i = 0; i < 4; i++) begin
      vl = 1 + int'(next_rand() % 16);
      vd = lane_pkg::vreg_t'(next_rand());
      run_insn(lane_pkg::VSUB, vd, 5'd20, 5'd21, vl);
      store_reg(vd, 16);
      store_reg(5'd21, vl);
    end

    // Same bank for both operands, and vd on top of vs1
    run_insn(lane_pkg::VADD, 5'd3, 5'd5, 5'd5, 16);
    store_reg(5'd3, 16);
    run_insn(lane_pkg::VSUB, 5'd4, 5'd6, lane_pkg::vreg_t'(6 + NrBanks), 16);
    store_reg(5'd4, 16);
    run_insn(lane_pkg::VOR, 5'd13, 5'd13, 5'd14, 16);
    store_reg(5'd13, 16);
    run_insn(lane_pkg::VAND, 5'd15, 5'd15, 5'd15, 9);
    store_reg(5'd15, 16);

    // Store port back-pressure
    bp_en <= 1'b1;
    for (int r = 16; r < 20; r++) store_reg(r, 16);
    run_insn(lane_pkg::VXOR, 5'd22, 5'd23, 5'd24, 16);
    store_reg(5'd22, 16);

    // Random instruction mix, done pulses counted at the end
    for (int i = 0; i < 30; i++) begin
      sel = 3'(next_rand() % 6);
      op  = lane_pkg::op_e'(sel);
      vd  = lane_pkg::vreg_t'(next_rand());
      vs1 = lane_pkg::vreg_t'(next_rand());
      vs2 = lane_pkg::vreg_t'(next_rand());
      vl  = 1 + int'(next_rand() % 16);
      run_insn(op, vd, vs1, vs2, vl);
    end
    for (int r = 0; r < lane_pkg::NrVRegs; r++) store_reg(r, 16);
    bp_en <= 1'b0;

    repeat (5) @(posedge clk_i);
    check_value(accepted, done_cnt, "done pulses against accepted instructions");
    $display("TEST PASS");
    $finish;
  end

endmodule
